/* compile.f */
+incdir+sim
hw/ddr3_sched_pkg.sv
hw/ddr3_req_arbiter.sv
hw/ddr3_bank_tracker.sv
hw/ddr3_cmd_fsm.sv
hw/ddr3_cmd_queue.sv
hw/ddr3_sched_top.sv
sim/ddr3_sched_tb.sv

/* sim/ddr3_sched_tb_tasks.svh */
`ifndef DDR3_SCHED_TB_TASKS_SVH
`define DDR3_SCHED_TB_TASKS_SVH
`default_nettype none

  // row, then bank, then column from high bits to low
  function automatic logic [ADDR_BITS-1:0] make_adr(input logic [ROW_BITS-1:0] row,
                                                   input logic [BANK_BITS-1:0] ba,
                                                   input logic [COL_BITS-1:0] col);
    return {row, ba, col};
  endfunction

  function automatic void add_expected(input ddr3_sched_pkg::ddr3_cmd_e cmd,
                                       input logic [TID_BITS-1:0] tid,
                                       input logic [BANK_BITS-1:0] ba,
                                       input logic [ROW_BITS-1:0] adr);
    ddr3_sched_pkg::ddr3_cmd_t c;
    c.cmd = cmd;
    c.tid = tid;
    c.ba  = ba;
    c.adr = adr;
    exp_q.push_back(c);
  endfunction

  // precharge all has A10 set and bank zero
  function automatic void close_all_banks();
    add_expected(ddr3_sched_pkg::PREC, '0, '0, ROW_BITS'(1 << ddr3_sched_pkg::PREA_BIT));
    bank_open = '0;
  endfunction

  function automatic void add_refresh();
    add_expected(ddr3_sched_pkg::REFR, '0, '0, '0);
  endfunction

  // hit gives the access only, miss adds ACTV, conflict adds PREC before it
  function automatic void predict_request(input bit is_wr, input logic [TID_BITS-1:0] tid,
                                          input logic [ROW_BITS-1:0] row,
                                          input logic [BANK_BITS-1:0] ba,
                                          input logic [COL_BITS-1:0] col);
    if (bank_open[ba] && bank_row[ba] != row) begin
      add_expected(ddr3_sched_pkg::PREC, tid, ba, '0);
      bank_open[ba] = 1'b0;
    end
    if (!bank_open[ba]) begin
      add_expected(ddr3_sched_pkg::ACTV, tid, ba, row);
      bank_open[ba] = 1'b1;
      bank_row[ba]  = row;
    end
    add_expected(is_wr ? ddr3_sched_pkg::WRIT : ddr3_sched_pkg::READ, tid, ba,
                 ROW_BITS'({col, 3'b000}));
  endfunction

  // req stays high into the next request, so back-to-back calls keep the port busy
  task automatic drive_req(input bit is_wr, input logic [TID_BITS-1:0] tid,
                           input logic [ADDR_BITS-1:0] adr);
    int waited;
    bit acked;
    @(negedge clock);
    if (is_wr) begin
      mem_wrreq = 1'b1;
      mem_wrtid = tid;
      mem_wradr = adr;
    end else begin
      mem_rdreq = 1'b1;
      mem_rdtid = tid;
      mem_rdadr = adr;
    end
    waited = 0;
    acked  = 1'b0;
    while (!acked && waited < ACK_WAIT) begin
      @(posedge clock);
      acked = is_wr ? mem_wrack : mem_rdack;
      waited++;
    end
    if (!acked) begin
      other_errs++;
      $display("no ack within %0d cycles for %s request tid %0d", ACK_WAIT,
               is_wr ? "write" : "read", tid);
    end
  endtask

  task automatic release_port(input bit is_wr);
    @(negedge clock);
    if (is_wr) begin
      mem_wrreq = 1'b0;
    end else begin
      mem_rdreq = 1'b0;
    end
  endtask

  // wait until every expected command was accepted, then idle a little
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_WAIT) begin
      @(negedge clock);
      waited++;
    end
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("%0d expected commands never arrived by time %0t", exp_q.size(), $time);
      exp_q.delete();
    end
    repeat (4) @(negedge clock);
  endtask

  task automatic check_acks(input int base_wr, input int base_rd, input int n_wr,
                            input int n_rd);
    assert (wr_acks - base_wr == n_wr && rd_acks - base_rd == n_rd) else begin
      val_errs++;
      $display("error %0t: acks wr %0d rd %0d, expected wr %0d rd %0d", $time,
               wr_acks - base_wr, rd_acks - base_rd, n_wr, n_rd);
    end
  endtask

  task automatic reset_and_init();
    // called at the falling edge where reset drops
    assert (!ddl_req && !mem_wrack && !mem_rdack) else begin
      val_errs++;
      $display("error %0t: req %b wrack %b rdack %b after reset", $time, ddl_req,
               mem_wrack, mem_rdack);
    end
    close_all_banks();
    wait_drain();
    // anything after the init precharge shows up in the monitor
    repeat (10) @(negedge clock);
  endtask

  task automatic miss_then_hit();
    int base_wr;
    int base_rd;
    base_wr = wr_acks;
    base_rd = rd_acks;
    predict_request(1'b1, 4'h1, 13'h0123, 3'd2, 7'h05);
    predict_request(1'b1, 4'h2, 13'h0123, 3'd2, 7'h2a);
    drive_req(1'b1, 4'h1, make_adr(13'h0123, 3'd2, 7'h05));
    drive_req(1'b1, 4'h2, make_adr(13'h0123, 3'd2, 7'h2a));
    release_port(1'b1);
    wait_drain();
    check_acks(base_wr, base_rd, 2, 0);
  endtask

  task automatic conflict_and_mapping();
    int base_wr;
    int base_rd;
    base_wr = wr_acks;
    base_rd = rd_acks;
    // bank 2 holds row 0x123, so this row conflicts
    predict_request(1'b0, 4'h3, 13'h1456, 3'd2, 7'h51);
    drive_req(1'b0, 4'h3, make_adr(13'h1456, 3'd2, 7'h51));
    release_port(1'b0);
    wait_drain();
    check_acks(base_wr, base_rd, 0, 1);
  endtask

  task automatic refresh_service();
    int base_wr;
    int base_rd;
    base_wr = wr_acks;
    base_rd = rd_acks;
    close_all_banks();
    add_refresh();
    add_refresh();
    // the second pulse lands while the first one is being served
    @(negedge clock);
    ddl_ref = 1'b1;
    @(negedge clock);
    ddl_ref = 1'b0;
    @(negedge clock);
    ddl_ref = 1'b1;
    @(negedge clock);
    ddl_ref = 1'b0;
    wait_drain();
    // the row that was open before the refresh is closed now
    predict_request(1'b0, 4'h4, 13'h1456, 3'd2, 7'h12);
    drive_req(1'b0, 4'h4, make_adr(13'h1456, 3'd2, 7'h12));
    release_port(1'b0);
    wait_drain();
    check_acks(base_wr, base_rd, 0, 1);
  endtask

  task automatic back_pressure();
    int                        base_wr;
    int                        base_rd;
    int                        waited;
    bit                        seq_done;
    ddr3_sched_pkg::ddr3_cmd_t held;
    ddr3_sched_pkg::ddr3_cmd_t cur;
    base_wr  = wr_acks;
    base_rd  = rd_acks;
    seq_done = 1'b0;
    @(negedge clock);
    ddl_rdy = 1'b0;
    // banks 4 to 7 are closed so each write needs ACTV and WRIT
    for (int i = 0; i < 4; i++) begin
      predict_request(1'b1, 4'(4 + i), 13'(100 + i), 3'(4 + i), 7'(8 * i));
    end
    fork
      begin
        for (int i = 0; i < 4; i++) begin
          drive_req(1'b1, 4'(4 + i), make_adr(13'(100 + i), 3'(4 + i), 7'(8 * i)));
        end
        release_port(1'b1);
        seq_done = 1'b1;
      end
      begin
        waited = 0;
        while (!ddl_req && waited < 20) begin
          @(negedge clock);
          waited++;
        end
        held = {ddl_cmd, ddl_tid, ddl_ba, ddl_adr};
        repeat (20) begin
          @(negedge clock);
          cur = {ddl_cmd, ddl_tid, ddl_ba, ddl_adr};
          assert (ddl_req && cur == held) else begin
            val_errs++;
            $display("error %0t: head moved or req low while rdy low, req %b", $time, ddl_req);
          end
        end
        // two writes fill the queue and the acks stop there
        check_acks(base_wr, base_rd, CMD_DEPTH / 2, 0);
        while (!seq_done) begin
          @(negedge clock);
          ddl_rdy = 1'($urandom % 2);
        end
      end
    join
    @(negedge clock);
    ddl_rdy = 1'b1;
    wait_drain();
    check_acks(base_wr, base_rd, 4, 0);
  endtask

  task automatic both_ports();
    logic [ADDR_BITS-1:0] wr_adr [BOTH_WR];
    logic [ADDR_BITS-1:0] rd_adr [BOTH_RD];
    bit                   order [$];
    bit                   last_wr;
    bit                   both;
    int                   streak;
    int                   wi;
    int                   ri;
    int                   ack_base;
    for (int i = 0; i < BOTH_WR; i++) begin
      wr_adr[i] = make_adr(13'(16 + i % 2), 3'(i % 4), 7'(i));
    end
    for (int i = 0; i < BOTH_RD; i++) begin
      rd_adr[i] = make_adr(13'(40 + i), 3'd1, 7'(3 * i));
    end
    // lone write sets the preferred direction
    predict_request(1'b1, 4'hf, 13'h0200, 3'd3, 7'h01);
    drive_req(1'b1, 4'hf, make_adr(13'h0200, 3'd3, 7'h01));
    release_port(1'b1);
    ack_base = ack_log.size();
    // serve order under the preference and streak rule
    last_wr = 1'b1;
    streak  = 0;
    wi      = 0;
    ri      = 0;
    while (wi < BOTH_WR || ri < BOTH_RD) begin
      both = (wi < BOTH_WR) && (ri < BOTH_RD);
      if (!both) begin
        // a lone port is served and nobody waits
        last_wr = wi < BOTH_WR;
        streak  = 0;
      end else begin
        // after a full streak the waiting port gets its turn
        if (streak == STREAK_MAX) begin
          last_wr = !last_wr;
          streak  = 0;
        end
        streak++;
      end
      if (last_wr) begin
        predict_request(1'b1, 4'(1 + wi), 13'(16 + wi % 2), 3'(wi % 4), 7'(wi));
        wi++;
      end else begin
        predict_request(1'b0, 4'(8 + ri), 13'(40 + ri), 3'd1, 7'(3 * ri));
        ri++;
      end
      order.push_back(last_wr);
    end
    fork
      begin
        for (int i = 0; i < BOTH_WR; i++) begin
          drive_req(1'b1, 4'(1 + i), wr_adr[i]);
        end
        release_port(1'b1);
      end
      begin
        for (int i = 0; i < BOTH_RD; i++) begin
          drive_req(1'b0, 4'(8 + i), rd_adr[i]);
        end
        release_port(1'b0);
      end
    join
    wait_drain();
    for (int i = 0; i < order.size(); i++) begin
      assert (ack_log.size() > ack_base + i && ack_log[ack_base + i] == order[i]) else begin
        val_errs++;
        $display("error %0t: ack %0d went to the %s port", $time, i,
                 order[i] ? "read" : "write");
      end
    end
  endtask

`default_nettype wire
`endif

/* sim/ddr3_sched_tb.sv */
`default_nettype none

module ddr3_sched_tb;

  localparam int CMD_DEPTH  = 4;
  localparam int STREAK_MAX = 4;
  localparam int ROW_BITS   = ddr3_sched_pkg::ROW_BITS;
  localparam int BANK_BITS  = ddr3_sched_pkg::BANK_BITS;
  localparam int COL_BITS   = ddr3_sched_pkg::COL_BITS;
  localparam int ADDR_BITS  = ddr3_sched_pkg::ADDR_BITS;
  localparam int TID_BITS   = ddr3_sched_pkg::TID_BITS;
  localparam int NUM_BANKS  = 1 << BANK_BITS;
  // limits in cycles for one ack and for one drain
  localparam int ACK_WAIT   = 200;
  localparam int DRAIN_WAIT = 300;
  // the six tests need a few hundred cycles, this leaves a wide margin
  localparam int TIMEOUT_CYCLES = 4000;
  // request counts for the two-port test
  localparam int BOTH_WR = 6;
  localparam int BOTH_RD = 3;

  logic                      clock;
  logic                      reset;
  logic                      mem_wrreq;
  logic [TID_BITS-1:0]       mem_wrtid;
  logic [ADDR_BITS-1:0]      mem_wradr;
  logic                      mem_wrack;
  logic                      mem_rdreq;
  logic [TID_BITS-1:0]       mem_rdtid;
  logic [ADDR_BITS-1:0]      mem_rdadr;
  logic                      mem_rdack;
  logic                      ddl_rdy;
  logic                      ddl_ref;
  logic                      ddl_req;
  ddr3_sched_pkg::ddr3_cmd_e ddl_cmd;
  logic [TID_BITS-1:0]       ddl_tid;
  logic [BANK_BITS-1:0]      ddl_ba;
  logic [ROW_BITS-1:0]       ddl_adr;

  // expected command stream, filled by the tests before they drive requests
  ddr3_sched_pkg::ddr3_cmd_t exp_q [$];
  ddr3_sched_pkg::ddr3_cmd_t mon_exp;
  // 1 for a write ack, 0 for a read ack, in arrival order
  bit                        ack_log [$];
  int                        wr_acks    = 0;
  int                        rd_acks    = 0;
  int                        val_errs   = 0;
  int                        other_errs = 0;
  // bank model, mirrors what the DRAM would have open
  logic [NUM_BANKS-1:0]      bank_open;
  logic [ROW_BITS-1:0]       bank_row [NUM_BANKS];

  ddr3_sched_top #(
    .CMD_DEPTH   (CMD_DEPTH),
    .STREAK_MAX  (STREAK_MAX),
    .BANK_ROW_COL(0)
  ) u_ddr3_sched_top (
    .clock      (clock),
    .reset      (reset),
    .mem_wrreq_i(mem_wrreq),
    .mem_wrtid_i(mem_wrtid),
    .mem_wradr_i(mem_wradr),
    .mem_wrack_o(mem_wrack),
    .mem_rdreq_i(mem_rdreq),
    .mem_rdtid_i(mem_rdtid),
    .mem_rdadr_i(mem_rdadr),
    .mem_rdack_o(mem_rdack),
    .ddl_rdy_i  (ddl_rdy),
    .ddl_ref_i  (ddl_ref),
    .ddl_req_o  (ddl_req),
    .ddl_cmd_o  (ddl_cmd),
    .ddl_tid_o  (ddl_tid),
    .ddl_ba_o   (ddl_ba),
    .ddl_adr_o  (ddl_adr)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // command monitor, a command is accepted when req and rdy are both high
  always @(posedge clock) begin
    if (!reset && ddl_req && ddl_rdy) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("unexpected command %s accepted at time %0t", ddl_cmd.name(), $time);
      end else begin
        mon_exp = exp_q.pop_front();
        // tid only matters on the access commands
        assert (ddl_cmd == mon_exp.cmd && ddl_ba == mon_exp.ba && ddl_adr == mon_exp.adr &&
                (!(mon_exp.cmd inside {ddr3_sched_pkg::READ, ddr3_sched_pkg::WRIT}) ||
                 ddl_tid == mon_exp.tid))
        else begin
          val_errs++;
          $display("error %0t: got %s tid %0d ba %0d adr %h, expected %s tid %0d ba %0d adr %h",
                   $time, ddl_cmd.name(), ddl_tid, ddl_ba, ddl_adr,
                   mon_exp.cmd.name(), mon_exp.tid, mon_exp.ba, mon_exp.adr);
        end
      end
    end
  end

  // ack history
  always @(posedge clock) begin
    if (!reset) begin
      if (mem_wrack) begin
        wr_acks++;
        ack_log.push_back(1'b1);
      end
      if (mem_rdack) begin
        rd_acks++;
        ack_log.push_back(1'b0);
      end
    end
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("run stopped by the watchdog after %0d cycles", TIMEOUT_CYCLES);
    $display("sim failed");
    $finish;
  end

  initial begin
    void'($urandom(8));
    reset     = 1'b1;
    mem_wrreq = 1'b0;
    mem_wrtid = '0;
    mem_wradr = '0;
    mem_rdreq = 1'b0;
    mem_rdtid = '0;
    mem_rdadr = '0;
    ddl_rdy   = 1'b1;
    ddl_ref   = 1'b0;
    bank_open = '0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    reset_and_init();
    miss_then_hit();
    conflict_and_mapping();
    refresh_service();
    back_pressure();
    both_ports();
    $display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
    if (val_errs + other_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  `include "ddr3_sched_tb_tasks.svh"

endmodule

`default_nettype wire

/* hw/ddr3_sched_top.sv */
`default_nettype none

module ddr3_sched_top #(
  parameter int CMD_DEPTH    = 4,
  parameter int STREAK_MAX   = 4,
  parameter int BANK_ROW_COL = 0
) (
  input  logic                                 clock,
  input  logic                                 reset,
  // write-request port
  input  logic                                 mem_wrreq_i,
  input  logic [ddr3_sched_pkg::TID_BITS-1:0]  mem_wrtid_i,
  input  logic [ddr3_sched_pkg::ADDR_BITS-1:0] mem_wradr_i,
  output logic                                 mem_wrack_o,
  // read-request port
  input  logic                                 mem_rdreq_i,
  input  logic [ddr3_sched_pkg::TID_BITS-1:0]  mem_rdtid_i,
  input  logic [ddr3_sched_pkg::ADDR_BITS-1:0] mem_rdadr_i,
  output logic                                 mem_rdack_o,
  // data layer side
  input  logic                                 ddl_rdy_i,
  input  logic                                 ddl_ref_i,
  output logic                                 ddl_req_o,
  output ddr3_sched_pkg::ddr3_cmd_e            ddl_cmd_o,
  output logic [ddr3_sched_pkg::TID_BITS-1:0]  ddl_tid_o,
  output logic [ddr3_sched_pkg::BANK_BITS-1:0] ddl_ba_o,
  output logic [ddr3_sched_pkg::ROW_BITS-1:0]  ddl_adr_o
);

  logic                                 pick_valid;
  ddr3_sched_pkg::ddr3_req_t            pick;
  logic                                 pick_take;
  logic [ddr3_sched_pkg::BANK_BITS-1:0] look_ba;
  logic [ddr3_sched_pkg::ROW_BITS-1:0]  look_row;
  logic                                 look_hit;
  logic                                 look_conflict;
  logic                                 push;
  ddr3_sched_pkg::ddr3_cmd_t            push_cmd;
  logic                                 full;
  logic                                 empty;
  logic                                 pop;
  ddr3_sched_pkg::ddr3_cmd_t            head;

  // a command leaves when the data layer takes the queue head
  assign ddl_req_o = !empty;
  assign pop       = ddl_req_o && ddl_rdy_i;
  assign ddl_cmd_o = head.cmd;
  assign ddl_tid_o = head.tid;
  assign ddl_ba_o  = head.ba;
  assign ddl_adr_o = head.adr;

  ddr3_req_arbiter #(
    .STREAK_MAX  (STREAK_MAX),
    .BANK_ROW_COL(BANK_ROW_COL)
  ) u_arbiter (
    .clock       (clock),
    .reset       (reset),
    .mem_wrreq_i (mem_wrreq_i),
    .mem_wrtid_i (mem_wrtid_i),
    .mem_wradr_i (mem_wradr_i),
    .mem_wrack_o (mem_wrack_o),
    .mem_rdreq_i (mem_rdreq_i),
    .mem_rdtid_i (mem_rdtid_i),
    .mem_rdadr_i (mem_rdadr_i),
    .mem_rdack_o (mem_rdack_o),
    .pick_valid_o(pick_valid),
    .pick_o      (pick),
    .pick_take_i (pick_take)
  );

  // tracker sees exactly the accepted pushes
  ddr3_bank_tracker u_tracker (
    .clock          (clock),
    .reset          (reset),
    .look_ba_i      (look_ba),
    .look_row_i     (look_row),
    .look_hit_o     (look_hit),
    .look_conflict_o(look_conflict),
    .upd_valid_i    (push),
    .upd_cmd_i      (push_cmd)
  );

  ddr3_cmd_fsm u_fsm (
    .clock          (clock),
    .reset          (reset),
    .pick_valid_i   (pick_valid),
    .pick_i         (pick),
    .ddl_ref_i      (ddl_ref_i),
    .look_hit_i     (look_hit),
    .look_conflict_i(look_conflict),
    .full_i         (full),
    .pick_take_o    (pick_take),
    .look_ba_o      (look_ba),
    .look_row_o     (look_row),
    .push_o         (push),
    .push_cmd_o     (push_cmd)
  );

  ddr3_cmd_queue #(
    .CMD_DEPTH(CMD_DEPTH)
  ) u_queue (
    .clock      (clock),
    .reset      (reset),
    .push_i     (push),
    .push_data_i(push_cmd),
    .full_o     (full),
    .pop_i      (pop),
    .empty_o    (empty),
    .head_o     (head)
  );

endmodule

`default_nettype wire

/* hw/ddr3_cmd_queue.sv */
`default_nettype none

module ddr3_cmd_queue #(
  parameter int CMD_DEPTH = 4
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      push_i,
  input  ddr3_sched_pkg::ddr3_cmd_t push_data_i,
  output logic                      full_o,
  input  logic                      pop_i,
  output logic                      empty_o,
  output ddr3_sched_pkg::ddr3_cmd_t head_o
);

  localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
  localparam int CNT_W = $clog2(CMD_DEPTH + 1);

  // circular storage, head is read straight from it
  ddr3_sched_pkg::ddr3_cmd_t mem_q [CMD_DEPTH];
  logic [PTR_W-1:0]          wr_ptr_q;
  logic [PTR_W-1:0]          rd_ptr_q;
  logic [CNT_W-1:0]          count_q;

  // wrap at CMD_DEPTH, so the depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(CMD_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign empty_o = count_q == '0;
  // a pop in the same cycle frees the slot the push needs
  assign full_o  = (count_q == CNT_W'(CMD_DEPTH)) && !pop_i;
  assign head_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // payload only, no reset
  always_ff @(posedge clock) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // the scheduler respects full, the data layer only pops a valid head
  a_no_overflow : assert property (@(posedge clock) disable iff (reset)
    push_i |-> !full_o);
  a_no_underflow : assert property (@(posedge clock) disable iff (reset)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* hw/ddr3_cmd_fsm.sv */
`default_nettype none

module ddr3_cmd_fsm (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 pick_valid_i,
  input  ddr3_sched_pkg::ddr3_req_t            pick_i,
  input  logic                                 ddl_ref_i,
  input  logic                                 look_hit_i,
  input  logic                                 look_conflict_i,
  input  logic                                 full_i,
  output logic                                 pick_take_o,
  output logic [ddr3_sched_pkg::BANK_BITS-1:0] look_ba_o,
  output logic [ddr3_sched_pkg::ROW_BITS-1:0]  look_row_o,
  output logic                                 push_o,
  output ddr3_sched_pkg::ddr3_cmd_t            push_cmd_o
);

  localparam int ROW_BITS = ddr3_sched_pkg::ROW_BITS;
  localparam int COL_BITS = ddr3_sched_pkg::COL_BITS;
  // zero bits above the shifted column
  localparam int COL_PAD  = ROW_BITS - COL_BITS - 3;

  typedef enum logic [2:0] {
    ST_INIT,
    ST_IDLE,
    ST_PREC,
    ST_ACTV,
    ST_ACCESS,
    ST_PREA,
    ST_REFR
  } state_e;

  state_e      state_q;
  state_e      state_d;
  // pending refresh requests, saturating at 7
  logic [2:0]  ref_cnt_q;
  logic [3:0]  ref_sum;
  logic        ref_dec;
  logic        want_push;

  // lookup always follows the current pick
  assign look_ba_o  = pick_i.ba;
  assign look_row_o = pick_i.row;

  // one refresh retires per accepted REFR push
  assign ref_dec = (state_q == ST_REFR) && !full_i;
  assign ref_sum = 4'(ref_cnt_q) + 4'(ddl_ref_i) - 4'(ref_dec);

  always_comb begin
    state_d        = state_q;
    want_push      = 1'b0;
    pick_take_o    = 1'b0;
    push_cmd_o.cmd = ddr3_sched_pkg::NOOP;
    push_cmd_o.tid = pick_i.tid;
    push_cmd_o.ba  = pick_i.ba;
    push_cmd_o.adr = '0;
    case (state_q)
      ST_INIT: begin
        // one precharge all on leaving reset
        want_push      = 1'b1;
        push_cmd_o.cmd = ddr3_sched_pkg::PREC;
        push_cmd_o.ba  = '0;
        push_cmd_o.adr[ddr3_sched_pkg::PREA_BIT] = 1'b1;
        if (!full_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_IDLE: begin
        // refresh goes ahead of a new request
        if (ref_cnt_q != 3'd0) begin
          state_d = ST_PREA;
        end else if (pick_valid_i) begin
          if (look_hit_i) begin
            state_d = ST_ACCESS;
          end else if (look_conflict_i) begin
            state_d = ST_PREC;
          end else begin
            state_d = ST_ACTV;
          end
        end
      end
      ST_PREC: begin
        // close the wrong row in this bank only
        want_push      = 1'b1;
        push_cmd_o.cmd = ddr3_sched_pkg::PREC;
        if (!full_i) begin
          state_d = ST_ACTV;
        end
      end
      ST_ACTV: begin
        want_push      = 1'b1;
        push_cmd_o.cmd = ddr3_sched_pkg::ACTV;
        push_cmd_o.adr = pick_i.row;
        if (!full_i) begin
          state_d = ST_ACCESS;
        end
      end
      ST_ACCESS: begin
        // column goes out as A[9:3], burst bits zero
        want_push      = 1'b1;
        push_cmd_o.cmd = pick_i.is_write ? ddr3_sched_pkg::WRIT : ddr3_sched_pkg::READ;
        push_cmd_o.adr = {{COL_PAD{1'b0}}, pick_i.col, 3'b000};
        pick_take_o    = !full_i;
        if (!full_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_PREA: begin
        want_push      = 1'b1;
        push_cmd_o.cmd = ddr3_sched_pkg::PREC;
        push_cmd_o.ba  = '0;
        push_cmd_o.adr[ddr3_sched_pkg::PREA_BIT] = 1'b1;
        if (!full_i) begin
          state_d = ST_REFR;
        end
      end
      ST_REFR: begin
        // late pulses keep us here, so they share this precharge all
        want_push      = 1'b1;
        push_cmd_o.cmd = ddr3_sched_pkg::REFR;
        push_cmd_o.ba  = '0;
        if (!full_i && (ref_sum == 4'd0)) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_INIT;
      end
    endcase
  end

  // back-pressure: nothing is pushed into a full queue
  assign push_o = want_push && !full_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q   <= ST_INIT;
      ref_cnt_q <= 3'd0;
    end else begin
      state_q <= state_d;
      if (ref_sum > 4'd7) begin
        ref_cnt_q <= 3'd7;
      end else begin
        ref_cnt_q <= ref_sum[2:0];
      end
    end
  end

  // the row must already be open in the tracker when the access goes out
  a_access_hit : assert property (@(posedge clock) disable iff (reset)
    push_o && (push_cmd_o.cmd inside {ddr3_sched_pkg::READ, ddr3_sched_pkg::WRIT})
    |-> look_hit_i);

endmodule

`default_nettype wire

/* hw/ddr3_bank_tracker.sv */
`default_nettype none

module ddr3_bank_tracker (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic [ddr3_sched_pkg::BANK_BITS-1:0] look_ba_i,
  input  logic [ddr3_sched_pkg::ROW_BITS-1:0]  look_row_i,
  output logic                                 look_hit_o,
  output logic                                 look_conflict_o,
  input  logic                                 upd_valid_i,
  input  ddr3_sched_pkg::ddr3_cmd_t            upd_cmd_i
);

  localparam int ROW_BITS  = ddr3_sched_pkg::ROW_BITS;
  localparam int NUM_BANKS = 1 << ddr3_sched_pkg::BANK_BITS;

  // one open flag and one row register per bank
  logic [NUM_BANKS-1:0] open_q;
  logic [ROW_BITS-1:0]  row_q [NUM_BANKS];
  logic                 row_same;
  logic                 is_actv;
  logic                 is_prec;

  assign row_same = row_q[look_ba_i] == look_row_i;

  // closed bank gives neither, which is the miss case
  assign look_hit_o      = open_q[look_ba_i] && row_same;
  assign look_conflict_o = open_q[look_ba_i] && !row_same;

  assign is_actv = upd_valid_i && (upd_cmd_i.cmd == ddr3_sched_pkg::ACTV);
  assign is_prec = upd_valid_i && (upd_cmd_i.cmd == ddr3_sched_pkg::PREC);

  always_ff @(posedge clock) begin
    if (reset) begin
      // all banks idle
      open_q <= '0;
    end else if (is_actv) begin
      open_q[upd_cmd_i.ba] <= 1'b1;
    end else if (is_prec) begin
      // A10 high closes every bank at once
      if (upd_cmd_i.adr[ddr3_sched_pkg::PREA_BIT]) begin
        open_q <= '0;
      end else begin
        open_q[upd_cmd_i.ba] <= 1'b0;
      end
    end
  end

  // row only means something while the open flag is set
  always_ff @(posedge clock) begin
    if (is_actv) begin
      row_q[upd_cmd_i.ba] <= upd_cmd_i.adr;
    end
  end

  // the scheduler must close a bank before opening another row in it
  a_actv_closed : assert property (@(posedge clock) disable iff (reset)
    is_actv |-> !open_q[upd_cmd_i.ba]);

endmodule

`default_nettype wire

/* hw/ddr3_req_arbiter.sv */
`default_nettype none

module ddr3_req_arbiter #(
  parameter int STREAK_MAX   = 4,
  parameter int BANK_ROW_COL = 0
) (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 mem_wrreq_i,
  input  logic [ddr3_sched_pkg::TID_BITS-1:0]  mem_wrtid_i,
  input  logic [ddr3_sched_pkg::ADDR_BITS-1:0] mem_wradr_i,
  output logic                                 mem_wrack_o,
  input  logic                                 mem_rdreq_i,
  input  logic [ddr3_sched_pkg::TID_BITS-1:0]  mem_rdtid_i,
  input  logic [ddr3_sched_pkg::ADDR_BITS-1:0] mem_rdadr_i,
  output logic                                 mem_rdack_o,
  output logic                                 pick_valid_o,
  output ddr3_sched_pkg::ddr3_req_t            pick_o,
  input  logic                                 pick_take_i
);

  localparam int ROW_BITS  = ddr3_sched_pkg::ROW_BITS;
  localparam int BANK_BITS = ddr3_sched_pkg::BANK_BITS;
  localparam int COL_BITS  = ddr3_sched_pkg::COL_BITS;
  localparam int ADDR_BITS = ddr3_sched_pkg::ADDR_BITS;
  localparam int STREAK_W  = $clog2(STREAK_MAX + 1);

  ddr3_sched_pkg::ddr3_req_t wr_dec;
  ddr3_sched_pkg::ddr3_req_t rd_dec;
  // direction of the last grant, write after reset
  logic                last_wr_q;
  // grants in that direction made while the other port waited
  logic [STREAK_W-1:0] streak_q;
  // choice frozen between first presentation and take
  logic                lock_q;
  logic                lock_wr_q;
  logic                pref_wr;
  logic                sel_wr;
  logic                other_wait;

  // split {row, bank, col} or {bank, row, col}
  function automatic ddr3_sched_pkg::ddr3_req_t decode(
    input logic                                is_wr,
    input logic [ddr3_sched_pkg::TID_BITS-1:0] tid,
    input logic [ADDR_BITS-1:0]                adr
  );
    ddr3_sched_pkg::ddr3_req_t r;
    r.is_write = is_wr;
    r.tid      = tid;
    r.col      = adr[COL_BITS-1:0];
    if (BANK_ROW_COL == 1) begin
      r.ba  = adr[ADDR_BITS-1 -: BANK_BITS];
      r.row = adr[COL_BITS +: ROW_BITS];
    end else begin
      r.row = adr[ADDR_BITS-1 -: ROW_BITS];
      r.ba  = adr[COL_BITS +: BANK_BITS];
    end
    return r;
  endfunction

  assign wr_dec = decode(1'b1, mem_wrtid_i, mem_wradr_i);
  assign rd_dec = decode(1'b0, mem_rdtid_i, mem_rdadr_i);

  // turn around once the streak is used up
  assign pref_wr = (streak_q >= STREAK_W'(STREAK_MAX)) ? !last_wr_q : last_wr_q;

  always_comb begin
    if (lock_q) begin
      sel_wr = lock_wr_q;
    end else if (mem_wrreq_i && mem_rdreq_i) begin
      sel_wr = pref_wr;
    end else begin
      sel_wr = mem_wrreq_i;
    end
  end

  assign other_wait   = sel_wr ? mem_rdreq_i : mem_wrreq_i;
  assign pick_valid_o = lock_q || mem_wrreq_i || mem_rdreq_i;
  assign pick_o       = sel_wr ? wr_dec : rd_dec;
  // ack in the cycle the access command is pushed
  assign mem_wrack_o  = pick_take_i && sel_wr;
  assign mem_rdack_o  = pick_take_i && !sel_wr;

  always_ff @(posedge clock) begin
    if (reset) begin
      lock_q    <= 1'b0;
      lock_wr_q <= 1'b1;
      last_wr_q <= 1'b1;
      streak_q  <= '0;
    end else begin
      if (pick_take_i) begin
        lock_q    <= 1'b0;
        last_wr_q <= sel_wr;
        // uncontended grants do not count toward the streak
        if (!other_wait) begin
          streak_q <= '0;
        end else if (sel_wr != last_wr_q) begin
          streak_q <= STREAK_W'(1);
        end else if (streak_q < STREAK_W'(STREAK_MAX)) begin
          streak_q <= streak_q + 1'b1;
        end
      end else if (pick_valid_o) begin
        lock_q    <= 1'b1;
        lock_wr_q <= sel_wr;
      end
    end
  end

  // an ack only goes to a port that is still requesting, and never to both
  a_one_ack : assert property (@(posedge clock) disable iff (reset)
    (mem_wrack_o |-> mem_wrreq_i && !mem_rdack_o) and (mem_rdack_o |-> mem_rdreq_i));

endmodule

`default_nettype wire

/* hw/ddr3_sched_pkg.sv */
`default_nettype none

package ddr3_sched_pkg;

  // geometry of a 1Gb x16 device, burst-aligned addressing
  localparam int ROW_BITS  = 13;
  localparam int BANK_BITS = 3;
  // column without the low 3 bits of the BL8 burst
  localparam int COL_BITS  = 7;
  localparam int ADDR_BITS = ROW_BITS + BANK_BITS + COL_BITS;
  localparam int TID_BITS  = 4;

  // A10 selects precharge all on the address bus
  localparam int PREA_BIT = 10;

  // chip-select-low command pins {RAS#, CAS#, WE#}
  typedef enum logic [2:0] {
    NOOP = 3'b111,
    ZQCL = 3'b110,
    READ = 3'b101,
    WRIT = 3'b100,
    ACTV = 3'b011,
    PREC = 3'b010,
    REFR = 3'b001,
    MODE = 3'b000
  } ddr3_cmd_e;

  // one command as it leaves for the data layer
  typedef struct packed {
    ddr3_cmd_e             cmd;
    logic [TID_BITS-1:0]   tid;
    logic [BANK_BITS-1:0]  ba;
    // row for ACTV, column << 3 for READ/WRIT, A10 for PREC
    logic [ROW_BITS-1:0]   adr;
  } ddr3_cmd_t;

  // decoded request picked by the arbiter
  typedef struct packed {
    logic                  is_write;
    logic [TID_BITS-1:0]   tid;
    logic [ROW_BITS-1:0]   row;
    logic [BANK_BITS-1:0]  ba;
    logic [COL_BITS-1:0]   col;
  } ddr3_req_t;

endpackage

`default_nettype wire
